/* pito_csr_macros.svh */
`ifndef PITO_CSR_MACROS_SVH
`define PITO_CSR_MACROS_SVH

// Barrel size
`define PITO_NUM_HARTS 8

// Width of a hart index
`define PITO_HART_W 3

// Reset value of mtvec
`define PITO_BOOT_ADDR 32'h0000_0100

// First CSR of the per-hart MVU bank
`define PITO_MVU_CSR_BASE 12'h7C0

`endif

/* pito_pkg.sv */
`include "pito_csr_macros.svh"

package pito_pkg;

        typedef enum logic [11:0] {
                CSR_MSTATUS       = 12'h300,
                CSR_MIE           = 12'h304,
                CSR_MTVEC         = 12'h305,
                CSR_MEPC          = 12'h341,
                CSR_MCAUSE        = 12'h342,
                CSR_MIP           = 12'h344,
                CSR_MVU_WBASE     = `PITO_MVU_CSR_BASE,
                CSR_MVU_IBASE     = `PITO_MVU_CSR_BASE + 12'd1,
                CSR_MVU_OBASE     = `PITO_MVU_CSR_BASE + 12'd2,
                CSR_MVU_PRECISION = `PITO_MVU_CSR_BASE + 12'd3,
                CSR_MVU_LENGTH    = `PITO_MVU_CSR_BASE + 12'd4,
                CSR_MVU_COMMAND   = `PITO_MVU_CSR_BASE + 12'd5,
                CSR_MCYCLE        = 12'hB00,
                CSR_MHARTID       = 12'hF14
        } csr_addr_e;

        typedef enum logic [2:0] {
                CSR_READ  = 3'b000,
                CSR_WRITE = 3'b001,
                CSR_SET   = 3'b010,
                CSR_CLEAR = 3'b011,
                CSR_IDLE  = 3'b111      // Harts not holding the slot
        } csr_op_e;

        typedef struct packed {
                logic        valid;
                logic [31:0] cause;
                logic [31:0] tval;      // Offending CSR address
        } exception_t;

        typedef struct packed {
                logic        valid;
                logic [31:0] cause;     // Bit 31 set for interrupts
        } irq_evt_t;

        typedef struct packed {
                logic [31:0] wbaseaddr;
                logic [31:0] ibaseaddr;
                logic [31:0] obaseaddr;
                logic [31:0] precision;
                logic [31:0] length;
                logic [31:0] command;
        } mvu_cfg_t;

        typedef struct packed {
                csr_op_e     op;
                logic [11:0] addr;
                logic [31:0] wdata;
        } csr_req_t;

endpackage

/* rv32_hart_sched.sv */
`timescale 1ns/10ps
`include "pito_csr_macros.svh"

module rv32_hart_sched (
        input  logic                    clk,
        input  logic                    rst_n_i,
        input  logic                    stall_i,
        output logic [`PITO_HART_W-1:0] hart_id_o
);

        localparam logic [`PITO_HART_W-1:0] LAST_HART = `PITO_HART_W'(`PITO_NUM_HARTS - 1);

        logic [`PITO_HART_W-1:0] hart_id_q;

        // One issue slot per hart, in strict rotation
        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        hart_id_q <= '0;
                end else if (!stall_i) begin
                        if (hart_id_q == LAST_HART)
                                hart_id_q <= '0;
                        else
                                hart_id_q <= hart_id_q + 1'b1;
                end
        end

        assign hart_id_o = hart_id_q;

endmodule

/* rv32_irq_sync.sv */
`timescale 1ns/10ps

module rv32_irq_sync (
        input  logic       clk,
        input  logic       rst_n_i,
        input  logic [2:0] async_i,     // {external, timer, ipi}
        output logic [2:0] sync_o
);

        logic [2:0] meta_q;
        logic [2:0] sync_q;

        // Two stages per line against metastability
        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        meta_q <= '0;
                        sync_q <= '0;
                end else begin
                        meta_q <= async_i;
                        sync_q <= meta_q;
                end
        end

        assign sync_o = sync_q;

endmodule

/* rv32_csr.sv */
`timescale 1ns/10ps
`include "pito_csr_macros.svh"

module rv32_csr
        import pito_pkg::*;
#(
        parameter int unsigned HART_ID = 0
) (
        input  logic        clk,
        input  logic        rst_n_i,
        input  csr_req_t    req_i,
        input  logic        trap_i,
        input  logic [31:0] trap_pc_i,
        input  logic [31:0] trap_cause_i,
        input  logic [2:0]  irq_sync_i,         // {external, timer, software}
        input  logic        mvu_irq_i,
        output logic [31:0] csr_rdata_o,
        output exception_t  csr_exception_o,
        output mvu_cfg_t    mvu_cfg_o,
        output logic        mvu_start_o,
        output irq_evt_t    csr_irq_evt_o
);

        localparam int unsigned IRQ_SOFT  = 3;
        localparam int unsigned IRQ_TIMER = 7;
        localparam int unsigned IRQ_EXT   = 11;
        localparam int unsigned IRQ_MVU   = 16;
        localparam logic [31:0] EXC_ILLEGAL_INSTR = 32'd2;

        logic [31:0] mstatus_q;
        logic [31:0] mie_q;
        logic [31:0] mtvec_q;
        logic [31:0] mepc_q;
        logic [31:0] mcause_q;
        logic [31:0] mcycle_q;
        mvu_cfg_t    mvu_cfg_q;
        logic        mvu_irq_q;
        logic        mvu_start_q;

        csr_addr_e   addr;
        logic [31:0] rdata;
        logic [31:0] wval;
        logic [31:0] mip;
        logic [31:0] pending;
        logic        legal_addr;
        logic        read_only;
        logic        is_write;
        logic        illegal;
        logic        we;

        assign addr = csr_addr_e'(req_i.addr);

        // Synchronized lines go straight in, MVU line is registered here
        always_comb begin
                mip = '0;
                mip[IRQ_EXT] = irq_sync_i[2];
                mip[IRQ_TIMER] = irq_sync_i[1];
                mip[IRQ_SOFT] = irq_sync_i[0];
                mip[IRQ_MVU] = mvu_irq_q;
        end

        always_comb begin
                rdata = '0;
                legal_addr = 1'b1;
                read_only = 1'b0;
                case (addr)
                CSR_MSTATUS:       rdata = mstatus_q;
                CSR_MIE:           rdata = mie_q;
                CSR_MTVEC:         rdata = mtvec_q;
                CSR_MEPC:          rdata = mepc_q;
                CSR_MCAUSE:        rdata = mcause_q;
                CSR_MVU_WBASE:     rdata = mvu_cfg_q.wbaseaddr;
                CSR_MVU_IBASE:     rdata = mvu_cfg_q.ibaseaddr;
                CSR_MVU_OBASE:     rdata = mvu_cfg_q.obaseaddr;
                CSR_MVU_PRECISION: rdata = mvu_cfg_q.precision;
                CSR_MVU_LENGTH:    rdata = mvu_cfg_q.length;
                CSR_MVU_COMMAND:   rdata = mvu_cfg_q.command;
                CSR_MIP: begin
                        rdata = mip;
                        read_only = 1'b1;
                end
                CSR_MCYCLE: begin
                        rdata = mcycle_q;
                        read_only = 1'b1;
                end
                CSR_MHARTID: begin
                        rdata = 32'(HART_ID);
                        read_only = 1'b1;
                end
                default:           legal_addr = 1'b0;
                endcase
        end

        always_comb begin
                case (req_i.op)
                CSR_WRITE: wval = req_i.wdata;
                CSR_SET:   wval = rdata | req_i.wdata;
                CSR_CLEAR: wval = rdata & ~req_i.wdata;
                default:   wval = rdata;
                endcase
        end

        assign is_write = (req_i.op == CSR_WRITE) || (req_i.op == CSR_SET) ||
                          (req_i.op == CSR_CLEAR);
        assign illegal = (is_write || req_i.op == CSR_READ) &&
                         (!legal_addr || (is_write && read_only));
        assign we = is_write && !illegal;

        always_comb begin
                csr_exception_o = '0;
                if (illegal) begin
                        csr_exception_o.valid = 1'b1;
                        csr_exception_o.cause = EXC_ILLEGAL_INSTR;
                        csr_exception_o.tval = {20'd0, req_i.addr};
                end
        end

        // External first, then software, timer and MVU
        always_comb begin
                pending = mip & mie_q;
                csr_irq_evt_o = '0;
                if (mstatus_q[3] && pending != '0) begin
                        csr_irq_evt_o.valid = 1'b1;
                        if (pending[IRQ_EXT])
                                csr_irq_evt_o.cause = {1'b1, 31'(IRQ_EXT)};
                        else if (pending[IRQ_SOFT])
                                csr_irq_evt_o.cause = {1'b1, 31'(IRQ_SOFT)};
                        else if (pending[IRQ_TIMER])
                                csr_irq_evt_o.cause = {1'b1, 31'(IRQ_TIMER)};
                        else
                                csr_irq_evt_o.cause = {1'b1, 31'(IRQ_MVU)};
                end
        end

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        mstatus_q <= '0;
                        mie_q <= '0;
                        mtvec_q <= `PITO_BOOT_ADDR;
                        mepc_q <= '0;
                        mcause_q <= '0;
                        mcycle_q <= '0;
                        mvu_cfg_q <= '0;
                        mvu_irq_q <= 1'b0;
                        mvu_start_q <= 1'b0;
                end else begin
                        mcycle_q <= mcycle_q + 32'd1;
                        mvu_irq_q <= mvu_irq_i;
                        mvu_start_q <= we && (addr == CSR_MVU_COMMAND);  // Single-cycle launch
                        if (we) begin
                                case (addr)
                                CSR_MSTATUS:       mstatus_q <= wval;
                                CSR_MIE:           mie_q <= wval;
                                CSR_MTVEC:         mtvec_q <= wval;
                                CSR_MEPC:          mepc_q <= wval;
                                CSR_MCAUSE:        mcause_q <= wval;
                                CSR_MVU_WBASE:     mvu_cfg_q.wbaseaddr <= wval;
                                CSR_MVU_IBASE:     mvu_cfg_q.ibaseaddr <= wval;
                                CSR_MVU_OBASE:     mvu_cfg_q.obaseaddr <= wval;
                                CSR_MVU_PRECISION: mvu_cfg_q.precision <= wval;
                                CSR_MVU_LENGTH:    mvu_cfg_q.length <= wval;
                                CSR_MVU_COMMAND:   mvu_cfg_q.command <= wval;
                                default:           ;
                                endcase
                        end
                        if (trap_i) begin       // Trap commit wins over a CSR write
                                mepc_q <= trap_pc_i;
                                mcause_q <= trap_cause_i;
                        end
                end
        end

        assign csr_rdata_o = rdata;
        assign mvu_cfg_o = mvu_cfg_q;
        assign mvu_start_o = mvu_start_q;

endmodule

/* rv32_barrel_csrfiles.sv */
`timescale 1ns/10ps
`include "pito_csr_macros.svh"

module rv32_barrel_csrfiles
        import pito_pkg::*;
#(
        parameter int NUM_HARTS = `PITO_NUM_HARTS
) (
        input  logic                                       clk,
        input  logic                                       rst_n_i,
        input  logic [((NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1)-1:0] hart_id_i,
        input  csr_req_t                                   req_i,
        input  logic                                       trap_i,
        input  logic [31:0]                                trap_pc_i,
        input  logic [31:0]                                trap_cause_i,
        input  logic [2:0]                                 irq_sync_i,
        input  logic [NUM_HARTS-1:0]                       mvu_irq_i,
        output logic [31:0]                                csr_rdata_o,
        output exception_t                                 csr_exception_o,
        output mvu_cfg_t [NUM_HARTS-1:0]                   mvu_cfg_o,
        output logic [NUM_HARTS-1:0]                       mvu_start_o,
        output irq_evt_t [NUM_HARTS-1:0]                   csr_irq_evt_o
);

        localparam int HART_W = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

        csr_req_t    req_sigs   [NUM_HARTS];
        logic        trap_sigs  [NUM_HARTS];
        logic [31:0] rdata_sigs [NUM_HARTS];
        exception_t  exc_sigs   [NUM_HARTS];

        for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
                logic sel;

                assign sel = (hart_id_i == HART_W'(h));

                // Only the slot owner sees the request
                always_comb begin
                        if (sel) begin
                                req_sigs[h] = req_i;
                        end else begin
                                req_sigs[h].op = CSR_IDLE;
                                req_sigs[h].addr = '0;
                                req_sigs[h].wdata = '0;
                        end
                end

                assign trap_sigs[h] = trap_i && sel;

                rv32_csr #(
                        .HART_ID        (h)
                ) u_csr (
                        .clk            (clk),
                        .rst_n_i        (rst_n_i),
                        .req_i          (req_sigs[h]),
                        .trap_i         (trap_sigs[h]),
                        .trap_pc_i      (trap_pc_i),
                        .trap_cause_i   (trap_cause_i),
                        .irq_sync_i     (irq_sync_i),      // Broadcast to all harts
                        .mvu_irq_i      (mvu_irq_i[h]),
                        .csr_rdata_o    (rdata_sigs[h]),
                        .csr_exception_o(exc_sigs[h]),
                        .mvu_cfg_o      (mvu_cfg_o[h]),
                        .mvu_start_o    (mvu_start_o[h]),
                        .csr_irq_evt_o  (csr_irq_evt_o[h])
                );
        end

        assign csr_rdata_o = rdata_sigs[hart_id_i];
        assign csr_exception_o = exc_sigs[hart_id_i];

endmodule

/* pito_csr_top.sv */
`timescale 1ns/10ps
`include "pito_csr_macros.svh"

module pito_csr_top
        import pito_pkg::*;
(
        input  logic                             clk,
        input  logic                             rst_n_i,
        input  logic                             stall_i,
        input  csr_req_t                         req_i,
        input  logic                             trap_i,
        input  logic [31:0]                      trap_pc_i,
        input  logic [31:0]                      trap_cause_i,
        input  logic                             irq_i,
        input  logic                             time_irq_i,
        input  logic                             ipi_i,
        input  logic [`PITO_NUM_HARTS-1:0]       mvu_irq_i,
        output logic [`PITO_HART_W-1:0]          hart_id_o,
        output logic [31:0]                      csr_rdata_o,
        output exception_t                       csr_exception_o,
        output mvu_cfg_t [`PITO_NUM_HARTS-1:0]   mvu_cfg_o,
        output logic [`PITO_NUM_HARTS-1:0]       mvu_start_o,
        output irq_evt_t [`PITO_NUM_HARTS-1:0]   csr_irq_evt_o
);

        logic [`PITO_HART_W-1:0] hart_id;
        logic [2:0]              irq_sync;

        rv32_hart_sched u_sched (
                .clk      (clk),
                .rst_n_i  (rst_n_i),
                .stall_i  (stall_i),
                .hart_id_o(hart_id)
        );

        rv32_irq_sync u_irq_sync (
                .clk    (clk),
                .rst_n_i(rst_n_i),
                .async_i({irq_i, time_irq_i, ipi_i}),
                .sync_o (irq_sync)
        );

        rv32_barrel_csrfiles #(
                .NUM_HARTS      (`PITO_NUM_HARTS)
        ) u_csrfiles (
                .clk            (clk),
                .rst_n_i        (rst_n_i),
                .hart_id_i      (hart_id),
                .req_i          (req_i),
                .trap_i         (trap_i),
                .trap_pc_i      (trap_pc_i),
                .trap_cause_i   (trap_cause_i),
                .irq_sync_i     (irq_sync),
                .mvu_irq_i      (mvu_irq_i),
                .csr_rdata_o    (csr_rdata_o),
                .csr_exception_o(csr_exception_o),
                .mvu_cfg_o      (mvu_cfg_o),
                .mvu_start_o    (mvu_start_o),
                .csr_irq_evt_o  (csr_irq_evt_o)
        );

        assign hart_id_o = hart_id;

endmodule

/* pito_csr_sva.sv */
`timescale 1ns/10ps
`include "pito_csr_macros.svh"

module pito_csr_sva
        import pito_pkg::*;
#(
        parameter int NUM_HARTS = `PITO_NUM_HARTS
) (
        input logic                 clk,
        input logic                 rst_n_i,
        input csr_req_t             req_i,
        input logic [31:0]          csr_rdata_o,
        input exception_t           csr_exception_o,
        input logic [NUM_HARTS-1:0] mvu_start_o
);

        // Launch is a single-cycle pulse per hart
        a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
                (mvu_start_o & $past(mvu_start_o)) == '0)
                else $error("mvu_start high on two cycles in a row");

        a_idle_no_exc: assert property (@(posedge clk) disable iff (!rst_n_i)
                (req_i.op == CSR_IDLE) |-> !csr_exception_o.valid)
                else $error("exception raised while the selected op is idle");

        a_rdata_known: assert property (@(posedge clk) disable iff (!rst_n_i)
                (req_i.op != CSR_IDLE) |-> !$isunknown(csr_rdata_o))
                else $error("read data unknown during an access");

endmodule

bind rv32_barrel_csrfiles pito_csr_sva #(
        .NUM_HARTS      (NUM_HARTS)
) u_sva (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .csr_rdata_o    (csr_rdata_o),
        .csr_exception_o(csr_exception_o),
        .mvu_start_o    (mvu_start_o)
);

/* pito_csr_tb.sv */
`timescale 1ns/10ps
`include "pito_csr_macros.svh"

module pito_csr_tb
        import pito_pkg::*;
();

        localparam int TIMEOUT_CYCLES = 4000;   // About 8 tests of 60 slot waits

        logic                           clk = 1'b0;
        logic                           rst_n_i;
        logic                           stall_i;
        csr_req_t                       req_i;
        logic                           trap_i;
        logic [31:0]                    trap_pc_i;
        logic [31:0]                    trap_cause_i;
        logic                           irq_i;
        logic                           time_irq_i;
        logic                           ipi_i;
        logic [`PITO_NUM_HARTS-1:0]     mvu_irq_i;
        logic [`PITO_HART_W-1:0]        hart_id_o;
        logic [31:0]                    csr_rdata_o;
        exception_t                     csr_exception_o;
        mvu_cfg_t [`PITO_NUM_HARTS-1:0] mvu_cfg_o;
        logic [`PITO_NUM_HARTS-1:0]     mvu_start_o;
        irq_evt_t [`PITO_NUM_HARTS-1:0] csr_irq_evt_o;

        int    errors = 0;
        int    checks = 0;
        int    tests = 0;
        int    test_base = 0;
        int    cycles = 0;
        int    start_cnt [`PITO_NUM_HARTS] = '{default: 0};
        string cur_test;

        pito_csr_top dut_i (.*);

        always #5 clk = ~clk;

        // Counts launch pulses per hart at mid-cycle
        always @(negedge clk) begin
                for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
                        if (rst_n_i && mvu_start_o[h])
                                start_cnt[h] = start_cnt[h] + 1;
                end
        end

        always @(posedge clk) begin
                cycles = cycles + 1;
                if (cycles >= TIMEOUT_CYCLES) begin
                        $display("timeout: run did not finish within %0d cycles", cycles);
                        $display("RESULT: FAIL");
                        $finish;
                end
        end

        task automatic report_mismatch(input string what, input string exp_s, input string act_s);
                errors++;
                $display("error %s %s: expected %s, actual %s", cur_test, what, exp_s, act_s);
        endtask

        task automatic check_data(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
                checks++;
                if (act !== exp)
                        report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
        endtask

        task automatic check_hart(input string what, input logic [`PITO_HART_W-1:0] exp,
                                  input logic [`PITO_HART_W-1:0] act);
                checks++;
                if (act !== exp)
                        report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
        endtask

        task automatic check_exc(input string what, input exception_t exp, input exception_t act);
                checks++;
                if (act !== exp)
                        report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
        endtask

        task automatic check_evt(input string what, input irq_evt_t exp, input irq_evt_t act);
                checks++;
                if (act !== exp)
                        report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
        endtask

        task automatic check_cfg(input string what, input mvu_cfg_t exp, input mvu_cfg_t act);
                checks++;
                if (act !== exp)
                        report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
        endtask

        function automatic exception_t expected_illegal(input logic [11:0] csr);
                return '{valid: 1'b1, cause: 32'd2, tval: {20'd0, csr}};
        endfunction

        task automatic start_test(input string name);
                cur_test = name;
                test_base = errors;
        endtask

        task automatic end_test();
                tests++;
                if (errors == test_base)
                        $display("%s: passed", cur_test);
                else
                        $display("%s: failed with %0d errors", cur_test, errors - test_base);
        endtask

        // Waits for the hart's issue slot and holds the request for that cycle
        task automatic access_slot(input int hart, input csr_op_e cmd, input logic [11:0] csr,
                                   input logic [31:0] data, output logic [31:0] rdata,
                                   output exception_t exc);
                while (hart_id_o != `PITO_HART_W'(hart))
                        @(negedge clk);
                req_i = '{op: cmd, addr: csr, wdata: data};
                #1;
                rdata = csr_rdata_o;
                exc = csr_exception_o;
                @(negedge clk);
                req_i = '{op: CSR_IDLE, addr: 12'h000, wdata: 32'h0};
        endtask

        task automatic read_csr(input int hart, input logic [11:0] csr, output logic [31:0] rdata);
                exception_t exc;
                access_slot(hart, CSR_READ, csr, 32'h0, rdata, exc);
                check_exc("legal read", '0, exc);
        endtask

        task automatic write_csr(input int hart, input csr_op_e cmd, input logic [11:0] csr,
                                 input logic [31:0] data);
                logic [31:0] rdata;
                exception_t  exc;
                access_slot(hart, cmd, csr, data, rdata, exc);
                check_exc("legal write", '0, exc);
        endtask

        task automatic trap_slot(input int hart, input logic [31:0] pc, input logic [31:0] cause);
                while (hart_id_o != `PITO_HART_W'(hart))
                        @(negedge clk);
                trap_i = 1'b1;
                trap_pc_i = pc;
                trap_cause_i = cause;
                @(negedge clk);
                trap_i = 1'b0;
        endtask

        // The synchronizer delays each line by two cycles
        task automatic expect_event(input int hart, input irq_evt_t exp, input string what);
                int n;
                n = 0;
                while (csr_irq_evt_o[`PITO_HART_W'(hart)] !== exp && n < 10) begin
                        @(negedge clk);
                        n++;
                end
                check_evt(what, exp, csr_irq_evt_o[`PITO_HART_W'(hart)]);
        endtask

        task automatic reset_identity();
                logic [31:0] rdata;
                int          exp_hart;
                start_test("reset_identity");
                exp_hart = 1;                   // One rising edge since reset release
                for (int k = 0; k < `PITO_NUM_HARTS; k++) begin
                        check_hart("hart_id_o", `PITO_HART_W'(exp_hart), hart_id_o);
                        @(negedge clk);
                        exp_hart = (exp_hart + 1) % `PITO_NUM_HARTS;
                end
                stall_i = 1'b1;
                @(negedge clk);
                check_hart("hart_id_o stalled", `PITO_HART_W'(exp_hart), hart_id_o);
                stall_i = 1'b0;
                for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
                        read_csr(h, CSR_MTVEC, rdata);
                        check_data("mtvec", `PITO_BOOT_ADDR, rdata);
                        read_csr(h, CSR_MHARTID, rdata);
                        check_data("mhartid", 32'(h), rdata);
                        read_csr(h, CSR_MEPC, rdata);
                        check_data("mepc", 32'd0, rdata);
                        read_csr(h, CSR_MCAUSE, rdata);
                        check_data("mcause", 32'd0, rdata);
                end
                end_test();
        endtask

        task automatic read_modify_write();
                logic [31:0] mepc_m [`PITO_NUM_HARTS];
                logic [31:0] mie_m [`PITO_NUM_HARTS];
                logic [31:0] mask;
                logic [31:0] rdata;
                start_test("read_modify_write");
                for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
                        mepc_m[h] = $urandom;
                        write_csr(h, CSR_WRITE, CSR_MEPC, mepc_m[h]);
                end
                for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
                        mie_m[h] = 32'd0;               // Reset value
                        for (int k = 0; k < 2; k++) begin
                                mask = $urandom;
                                write_csr(h, CSR_SET, CSR_MIE, mask);
                                mie_m[h] = mie_m[h] | mask;
                        end
                        mask = $urandom;
                        write_csr(h, CSR_CLEAR, CSR_MIE, mask);
                        mie_m[h] = mie_m[h] & ~mask;
                end
                for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
                        read_csr(h, CSR_MEPC, rdata);
                        check_data("mepc", mepc_m[h], rdata);
                        read_csr(h, CSR_MIE, rdata);
                        check_data("mie", mie_m[h], rdata);
                end
                end_test();
        endtask

        task automatic illegal_access();
                logic [31:0] rdata;
                exception_t  exc;
                start_test("illegal_access");
                access_slot(5, CSR_WRITE, CSR_MHARTID, $urandom, rdata, exc);
                check_exc("write mhartid", expected_illegal(12'hF14), exc);
                read_csr(5, CSR_MHARTID, rdata);
                check_data("mhartid kept", 32'd5, rdata);
                access_slot(5, CSR_SET, CSR_MCYCLE, 32'hFFFF_FFFF, rdata, exc);
                check_exc("set mcycle", expected_illegal(12'hB00), exc);
                access_slot(5, CSR_READ, 12'h123, 32'h0, rdata, exc);
                check_exc("read 123h", expected_illegal(12'h123), exc);
                read_csr(5, CSR_MEPC, rdata);
                end_test();
        endtask

        task automatic mvu_launch();
                mvu_cfg_t cfg;
                int       base [`PITO_NUM_HARTS];
                int       hart;
                start_test("mvu_launch");
                base = start_cnt;
                for (int k = 0; k < 2; k++) begin
                        hart = (k == 0) ? 1 : 6;
                        cfg = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
                        write_csr(hart, CSR_WRITE, CSR_MVU_WBASE, cfg.wbaseaddr);
                        write_csr(hart, CSR_WRITE, CSR_MVU_IBASE, cfg.ibaseaddr);
                        write_csr(hart, CSR_WRITE, CSR_MVU_OBASE, cfg.obaseaddr);
                        write_csr(hart, CSR_WRITE, CSR_MVU_PRECISION, cfg.precision);
                        write_csr(hart, CSR_WRITE, CSR_MVU_LENGTH, cfg.length);
                        write_csr(hart, CSR_WRITE, CSR_MVU_COMMAND, cfg.command);
                        check_cfg("mvu_cfg_o", cfg, mvu_cfg_o[`PITO_HART_W'(hart)]);
                end
                repeat (2) @(negedge clk);
                for (int h = 0; h < `PITO_NUM_HARTS; h++)
                        check_data("mvu_start pulses", (h == 1 || h == 6) ? 32'd1 : 32'd0,
                                   32'(start_cnt[h] - base[h]));
                end_test();
        endtask

        task automatic irq_priority();
                start_test("irq_priority");
                write_csr(2, CSR_WRITE, CSR_MIE, 32'h0001_0888);
                write_csr(2, CSR_SET, CSR_MSTATUS, 32'h0000_0008);
                expect_event(2, '0, "no source");
                time_irq_i = 1'b1;
                expect_event(2, '{valid: 1'b1, cause: 32'h8000_0007}, "timer");
                ipi_i = 1'b1;
                expect_event(2, '{valid: 1'b1, cause: 32'h8000_0003}, "software over timer");
                irq_i = 1'b1;
                expect_event(2, '{valid: 1'b1, cause: 32'h8000_000B}, "external first");
                write_csr(2, CSR_CLEAR, CSR_MSTATUS, 32'h0000_0008);
                expect_event(2, '0, "global enable off");
                irq_i = 1'b0;
                time_irq_i = 1'b0;
                ipi_i = 1'b0;
                end_test();
        endtask

        task automatic trap_and_cycle();
                logic [31:0] pc;
                logic [31:0] cause;
                logic [31:0] first;
                logic [31:0] second;
                start_test("trap_and_cycle");
                pc = $urandom;
                cause = $urandom;
                trap_slot(4, pc, cause);
                read_csr(4, CSR_MEPC, first);
                check_data("mepc", pc, first);
                read_csr(4, CSR_MCAUSE, first);
                check_data("mcause", cause, first);
                read_csr(4, CSR_MCYCLE, first);
                read_csr(4, CSR_MCYCLE, second);
                checks++;
                if (second <= first) begin
                        errors++;
                        $display("%s: mcycle did not increase between two slots (%0d then %0d)",
                                 cur_test, first, second);
                end
                end_test();
        endtask

        initial begin
                void'($urandom(82491));
                rst_n_i = 1'b0;
                stall_i = 1'b0;
                req_i = '{op: CSR_IDLE, addr: 12'h000, wdata: 32'h0};
                trap_i = 1'b0;
                trap_pc_i = 32'h0;
                trap_cause_i = 32'h0;
                irq_i = 1'b0;
                time_irq_i = 1'b0;
                ipi_i = 1'b0;
                mvu_irq_i = '0;
                repeat (3) @(negedge clk);
                rst_n_i = 1'b1;
                @(negedge clk);
                reset_identity();
                read_modify_write();
                illegal_access();
                mvu_launch();
                irq_priority();
                trap_and_cycle();
                $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
                if (errors == 0)
                        $display("RESULT: PASS");
                else
                        $display("RESULT: FAIL");
                $finish;
        end

endmodule

/* list.f */
+incdir+.
pito_pkg.sv
rv32_hart_sched.sv
rv32_irq_sync.sv
rv32_csr.sv
rv32_barrel_csrfiles.sv
pito_csr_top.sv
pito_csr_sva.sv
pito_csr_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module pito_csr_tb -o pito_csr_sim
out=$(./obj_dir/pito_csr_sim)
echo "$out"
echo "$out" | grep -q "RESULT: PASS"
